// File: verilog/fe_pkg.sv
`default_nettype none

package fe_pkg;

  // fetch address and instruction widths
  localparam int addr_width_lp  = 32;
  localparam int instr_width_lp = 32;

  // instruction memory, indexed by pc[9:2]
  localparam int imem_words_lp      = 256;
  localparam int imem_addr_width_lp = 8;

  // branch history table, indexed by pc[7:2]
  localparam int bht_entries_lp   = 64;
  localparam int bht_idx_width_lp = 6;

  // jalr target table, index pc[4:2] and tag pc[12:5]
  localparam int btb_entries_lp   = 8;
  localparam int btb_idx_width_lp = 3;
  localparam int btb_tag_width_lp = 8;

  localparam logic [addr_width_lp-1:0] first_pc_lp = '0;

  // kind of message sent to the backend
  typedef enum logic
  {
    e_fe_fetch     = 1'b0,
    e_fe_exception = 1'b1
  } fe_msg_e;

  // control-flow class found by the scanner
  typedef enum logic [1:0]
  {
    e_class_other  = 2'd0,
    e_class_jal    = 2'd1,
    e_class_branch = 2'd2,
    e_class_jalr   = 2'd3
  } instr_class_e;

endpackage

`default_nettype wire

// File: verilog/fe_instr_scan.sv
`timescale 1ns/1ns
`default_nettype none

module fe_instr_scan
  (input  logic [fe_pkg::instr_width_lp-1:0] instr_i
   , output fe_pkg::instr_class_e            class_o
   , output logic [fe_pkg::addr_width_lp-1:0] imm_o
   );

  import fe_pkg::*;

  // rv32i major opcodes of the control-flow instructions
  typedef enum logic [6:0]
  {
    op_branch = 7'b1100011,
    op_jalr   = 7'b1100111,
    op_jal    = 7'b1101111
  } opcode_e;

  always_comb
    begin
      class_o = e_class_other;
      imm_o   = '0;
      case (instr_i[6:0])
        op_jal:
          begin
            class_o = e_class_jal;
            // j-type immediate, bit 0 always zero
            imm_o = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                     instr_i[30:21], 1'b0};
          end
        op_branch:
          begin
            class_o = e_class_branch;
            imm_o = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                     instr_i[11:8], 1'b0};
          end
        // jalr target comes from the btb, no immediate needed
        op_jalr: class_o = e_class_jalr;
        default: ;
      endcase
    end

endmodule

`default_nettype wire

// File: verilog/fe_bht.sv
`timescale 1ns/1ns
`default_nettype none

module fe_bht
  (input  logic                             clk_i
   , input  logic                           reset_i
   , input  logic [fe_pkg::addr_width_lp-1:0] r_pc_i
   , output logic                           predict_taken_o
   , input  logic                           w_v_i
   , input  logic [fe_pkg::addr_width_lp-1:0] w_pc_i
   , input  logic                           w_taken_i
   );

  import fe_pkg::*;

  logic [1:0]                  cnt_r [bht_entries_lp];
  logic [bht_idx_width_lp-1:0] r_idx;
  logic [bht_idx_width_lp-1:0] w_idx;

  assign r_idx = r_pc_i[bht_idx_width_lp+1:2];
  assign w_idx = w_pc_i[bht_idx_width_lp+1:2];

  // msb of the counter is the prediction, a same-cycle write is not seen
  assign predict_taken_o = cnt_r[r_idx][1];

  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        begin
          // weakly not taken
          for (int i = 0; i < bht_entries_lp; i++)
            cnt_r[i] <= 2'b01;
        end
      else if (w_v_i)
        begin
          if (w_taken_i && cnt_r[w_idx] != 2'b11)
            cnt_r[w_idx] <= cnt_r[w_idx] + 2'b01;
          else if (!w_taken_i && cnt_r[w_idx] != 2'b00)
            cnt_r[w_idx] <= cnt_r[w_idx] - 2'b01;
        end
    end

endmodule

`default_nettype wire

// File: verilog/fe_btb.sv
`timescale 1ns/1ns
`default_nettype none

module fe_btb
  (input  logic                               clk_i
   , input  logic                             reset_i
   , input  logic [fe_pkg::addr_width_lp-1:0] r_pc_i
   , output logic                             hit_o
   , output logic [fe_pkg::addr_width_lp-1:0] target_o
   , input  logic                             w_v_i
   , input  logic [fe_pkg::addr_width_lp-1:0] w_pc_i
   , input  logic [fe_pkg::addr_width_lp-1:0] w_target_i
   );

  import fe_pkg::*;

  localparam int tag_lsb_lp = btb_idx_width_lp + 2;
  localparam int tag_msb_lp = btb_idx_width_lp + btb_tag_width_lp + 1;

  logic [btb_entries_lp-1:0]   valid_r;
  logic [btb_tag_width_lp-1:0] tag_r    [btb_entries_lp];
  logic [addr_width_lp-1:0]    target_r [btb_entries_lp];

  logic [btb_idx_width_lp-1:0] r_idx;
  logic [btb_idx_width_lp-1:0] w_idx;

  assign r_idx = r_pc_i[btb_idx_width_lp+1:2];
  assign w_idx = w_pc_i[btb_idx_width_lp+1:2];

  assign hit_o    = valid_r[r_idx] && (tag_r[r_idx] == r_pc_i[tag_msb_lp:tag_lsb_lp]);
  assign target_o = target_r[r_idx];

  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        valid_r <= '0;
      else if (w_v_i)
        valid_r[w_idx] <= 1'b1;
    end

  // tag and target just follow the write strobe
  always_ff @(posedge clk_i)
    begin
      if (w_v_i)
        begin
          tag_r[w_idx]    <= w_pc_i[tag_msb_lp:tag_lsb_lp];
          target_r[w_idx] <= w_target_i;
        end
    end

endmodule

`default_nettype wire

// File: verilog/fe_imem.sv
`timescale 1ns/1ns
`default_nettype none

module fe_imem
  (input  logic                                    clk_i
   , input  logic                                  we_i
   , input  logic [fe_pkg::imem_addr_width_lp-1:0] waddr_i
   , input  logic [fe_pkg::instr_width_lp-1:0]     wdata_i
   , input  logic                                  re_i
   , input  logic [fe_pkg::imem_addr_width_lp-1:0] raddr_i
   , output logic [fe_pkg::instr_width_lp-1:0]     rdata_o
   );

  import fe_pkg::*;

  logic [instr_width_lp-1:0] mem_r [imem_words_lp];

  // load port, one word per strobe
  always_ff @(posedge clk_i)
    begin
      if (we_i)
        mem_r[waddr_i] <= wdata_i;
    end

  // registered read, data holds while re_i is low
  always_ff @(posedge clk_i)
    begin
      if (re_i)
        rdata_o <= mem_r[raddr_i];
    end

endmodule

`default_nettype wire

// File: verilog/fe_pc_gen.sv
`timescale 1ns/1ns
`default_nettype none

module fe_pc_gen
  (input  logic                                    clk_i
   , input  logic                                  reset_i
   , input  logic                                  redirect_v_i
   , input  logic [fe_pkg::addr_width_lp-1:0]      redirect_pc_i
   , output logic                                  imem_re_o
   , output logic [fe_pkg::imem_addr_width_lp-1:0] imem_raddr_o
   , input  logic [fe_pkg::instr_width_lp-1:0]     imem_rdata_i
   , input  fe_pkg::instr_class_e                  class_i
   , input  logic [fe_pkg::addr_width_lp-1:0]      imm_i
   , output logic [fe_pkg::instr_width_lp-1:0]     instr_o
   , input  logic                                  bht_taken_i
   , input  logic                                  btb_hit_i
   , input  logic [fe_pkg::addr_width_lp-1:0]      btb_target_i
   , output logic [fe_pkg::addr_width_lp-1:0]      fetch_stage_pc_o
   , input  logic                                  fetch_ready_i
   , output logic                                  fetch_v_o
   , output fe_pkg::fe_msg_e                       fetch_msg_o
   , output logic [fe_pkg::addr_width_lp-1:0]      fetch_pc_o
   , output logic                                  fetch_pred_taken_o
   );

  import fe_pkg::*;

  logic [addr_width_lp-1:0] pc_r;
  logic [addr_width_lp-1:0] fetch_pc_r;
  logic                     fetch_v_r;
  logic                     exc_pending_r;
  logic                     halt_r;

  // prediction frozen while the output is stalled
  logic                     held_v_r;
  logic                     held_taken_r;
  logic [addr_width_lp-1:0] held_target_r;

  logic                     live_taken;
  logic [addr_width_lp-1:0] live_target;
  logic                     pred_taken;
  logic [addr_width_lp-1:0] pred_target;
  logic                     stall;
  logic                     misaligned;

  assign misaligned = redirect_v_i && (redirect_pc_i[1:0] != 2'b00);

  always_comb
    begin
      live_taken  = 1'b0;
      live_target = fetch_pc_r + imm_i;
      case (class_i)
        e_class_jal:    live_taken = fetch_v_r;
        e_class_branch: live_taken = fetch_v_r && bht_taken_i;
        e_class_jalr:
          begin
            live_taken  = fetch_v_r && btb_hit_i;
            live_target = btb_target_i;
          end
        default: ;
      endcase
    end

  // a training strobe during a stall must not change the held message
  assign pred_taken  = held_v_r ? held_taken_r  : live_taken;
  assign pred_target = held_v_r ? held_target_r : live_target;

  assign fetch_v_o          = fetch_v_r || exc_pending_r;
  assign fetch_msg_o        = exc_pending_r ? e_fe_exception : e_fe_fetch;
  assign fetch_pc_o         = fetch_pc_r;
  assign fetch_pred_taken_o = pred_taken;
  assign instr_o            = exc_pending_r ? '0 : imem_rdata_i;
  assign fetch_stage_pc_o   = fetch_pc_r;

  assign stall        = fetch_v_o && !fetch_ready_i;
  assign imem_re_o    = !halt_r && !stall;
  assign imem_raddr_o = pc_r[imem_addr_width_lp+1:2];

  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        begin
          pc_r          <= first_pc_lp;
          fetch_v_r     <= 1'b0;
          exc_pending_r <= 1'b0;
          halt_r        <= 1'b0;
        end
      else if (redirect_v_i)
        begin
          // squash both stages, a misaligned pc stops fetch
          pc_r          <= redirect_pc_i;
          fetch_v_r     <= 1'b0;
          exc_pending_r <= misaligned;
          halt_r        <= misaligned;
        end
      else if (!stall)
        begin
          exc_pending_r <= 1'b0;
          fetch_v_r     <= !halt_r && !pred_taken;
          if (!halt_r)
            pc_r <= pred_taken ? pred_target : pc_r + 32'd4;
        end
    end

  // the exception message reuses the fetch-stage pc
  always_ff @(posedge clk_i)
    begin
      if (redirect_v_i)
        fetch_pc_r <= redirect_pc_i;
      else if (imem_re_o)
        fetch_pc_r <= pc_r;
    end

  always_ff @(posedge clk_i)
    begin
      if (reset_i || redirect_v_i)
        held_v_r <= 1'b0;
      else
        held_v_r <= stall;
    end

  always_ff @(posedge clk_i)
    begin
      if (stall)
        begin
          held_taken_r  <= pred_taken;
          held_target_r <= pred_target;
        end
    end

endmodule

`default_nettype wire

// File: verilog/fe_top.sv
`timescale 1ns/1ns
`default_nettype none

module fe_top
  (input  logic                                    clk_i
   , input  logic                                  reset_i
   , input  logic                                  imem_we_i
   , input  logic [fe_pkg::imem_addr_width_lp-1:0] imem_addr_i
   , input  logic [fe_pkg::instr_width_lp-1:0]     imem_wdata_i
   , input  logic                                  redirect_v_i
   , input  logic [fe_pkg::addr_width_lp-1:0]      redirect_pc_i
   , input  logic                                  update_v_i
   , input  logic [fe_pkg::addr_width_lp-1:0]      update_pc_i
   , input  logic                                  update_is_jalr_i
   , input  logic                                  update_taken_i
   , input  logic [fe_pkg::addr_width_lp-1:0]      update_target_i
   , input  logic                                  fetch_ready_i
   , output logic                                  fetch_v_o
   , output fe_pkg::fe_msg_e                       fetch_msg_o
   , output logic [fe_pkg::addr_width_lp-1:0]      fetch_pc_o
   , output logic [fe_pkg::instr_width_lp-1:0]     fetch_instr_o
   , output logic                                  fetch_pred_taken_o
   );

  import fe_pkg::*;

  logic                          imem_re;
  logic [imem_addr_width_lp-1:0] imem_raddr;
  logic [instr_width_lp-1:0]     imem_rdata;
  instr_class_e                  scan_class;
  logic [addr_width_lp-1:0]      scan_imm;
  logic [addr_width_lp-1:0]      fetch_stage_pc;
  logic                          bht_taken;
  logic                          btb_hit;
  logic [addr_width_lp-1:0]      btb_target;

  fe_pc_gen pc_gen
    (.clk_i(clk_i), .reset_i(reset_i)
     ,.redirect_v_i(redirect_v_i), .redirect_pc_i(redirect_pc_i)
     ,.imem_re_o(imem_re), .imem_raddr_o(imem_raddr), .imem_rdata_i(imem_rdata)
     ,.class_i(scan_class), .imm_i(scan_imm), .instr_o(fetch_instr_o)
     ,.bht_taken_i(bht_taken), .btb_hit_i(btb_hit), .btb_target_i(btb_target)
     ,.fetch_stage_pc_o(fetch_stage_pc)
     ,.fetch_ready_i(fetch_ready_i), .fetch_v_o(fetch_v_o), .fetch_msg_o(fetch_msg_o)
     ,.fetch_pc_o(fetch_pc_o), .fetch_pred_taken_o(fetch_pred_taken_o)
     );

  fe_imem imem
    (.clk_i(clk_i), .we_i(imem_we_i), .waddr_i(imem_addr_i), .wdata_i(imem_wdata_i)
     ,.re_i(imem_re), .raddr_i(imem_raddr), .rdata_o(imem_rdata)
     );

  fe_instr_scan scan
    (.instr_i(imem_rdata), .class_o(scan_class), .imm_o(scan_imm));

  // training goes to the bht for branches and to the btb for jalr
  fe_bht bht
    (.clk_i(clk_i), .reset_i(reset_i)
     ,.r_pc_i(fetch_stage_pc), .predict_taken_o(bht_taken)
     ,.w_v_i(update_v_i && !update_is_jalr_i), .w_pc_i(update_pc_i)
     ,.w_taken_i(update_taken_i)
     );

  fe_btb btb
    (.clk_i(clk_i), .reset_i(reset_i)
     ,.r_pc_i(fetch_stage_pc), .hit_o(btb_hit), .target_o(btb_target)
     ,.w_v_i(update_v_i && update_is_jalr_i), .w_pc_i(update_pc_i)
     ,.w_target_i(update_target_i)
     );

endmodule

`default_nettype wire

// File: sim/tb_fe.sv
`timescale 1ns/1ns
`default_nettype none

module tb_fe;

  import fe_pkg::*;

  // 48 words of program at pc 0x00 to 0xbc
  localparam int prog_words_lp = 48;
  // about 110 accepted messages plus load, halt windows and training
  localparam int max_cycles_lp = 4000;

  logic                          clk_i;
  logic                          reset_i;
  logic                          imem_we_i;
  logic [imem_addr_width_lp-1:0] imem_addr_i;
  logic [instr_width_lp-1:0]     imem_wdata_i;
  logic                          redirect_v_i;
  logic [addr_width_lp-1:0]      redirect_pc_i;
  logic                          update_v_i;
  logic [addr_width_lp-1:0]      update_pc_i;
  logic                          update_is_jalr_i;
  logic                          update_taken_i;
  logic [addr_width_lp-1:0]      update_target_i;
  logic                          fetch_ready_i;
  logic                          fetch_v_o;
  fe_msg_e                       fetch_msg_o;
  logic [addr_width_lp-1:0]      fetch_pc_o;
  logic [instr_width_lp-1:0]     fetch_instr_o;
  logic                          fetch_pred_taken_o;

  // reference model state
  logic [instr_width_lp-1:0] prog_word [imem_words_lp];
  instr_class_e              prog_cls  [imem_words_lp];
  logic [addr_width_lp-1:0]  prog_imm  [imem_words_lp];
  logic [1:0]                cnt_m     [bht_entries_lp];
  logic                      btb_v_m   [btb_entries_lp];
  logic [btb_tag_width_lp-1:0] btb_tag_m [btb_entries_lp];
  logic [addr_width_lp-1:0]  btb_tgt_m [btb_entries_lp];

  logic [addr_width_lp-1:0] exp_pc;
  logic                     exp_exc;
  logic                     exp_taken;
  logic [addr_width_lp-1:0] exp_target;
  logic                     halted_m;
  logic                     was_stalled;
  logic [65:0]              prev_out;
  logic [65:0]              out_vec;
  logic                     accept;
  int                       accept_count = 0;
  int                       cycle_count = 0;
  logic [31:0]              rnd_state = 32'hfddd_2d50;
  string                    test_name = "reset";

  fe_top dut
    (.clk_i(clk_i), .reset_i(reset_i)
     ,.imem_we_i(imem_we_i), .imem_addr_i(imem_addr_i), .imem_wdata_i(imem_wdata_i)
     ,.redirect_v_i(redirect_v_i), .redirect_pc_i(redirect_pc_i)
     ,.update_v_i(update_v_i), .update_pc_i(update_pc_i)
     ,.update_is_jalr_i(update_is_jalr_i), .update_taken_i(update_taken_i)
     ,.update_target_i(update_target_i)
     ,.fetch_ready_i(fetch_ready_i), .fetch_v_o(fetch_v_o), .fetch_msg_o(fetch_msg_o)
     ,.fetch_pc_o(fetch_pc_o), .fetch_instr_o(fetch_instr_o)
     ,.fetch_pred_taken_o(fetch_pred_taken_o)
     );

  initial
    begin
      clk_i = 1'b0;
      forever #4 clk_i = ~clk_i;
    end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // j-type layout imm[20|10:1|11|19:12] with rd x0
  function automatic logic [31:0] encode_jal(input logic [31:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd0, 7'b1101111};
  endfunction

  // beq x0, x0 with b-type layout imm[12|10:5] and imm[4:1|11]
  function automatic logic [31:0] encode_beq(input logic [31:0] imm);
    return {imm[12], imm[10:5], 5'd0, 5'd0, 3'b000, imm[4:1], imm[11], 7'b1100011};
  endfunction

  task automatic report_mismatch(input string what, input logic [65:0] expected,
                                 input logic [65:0] actual);
    $display("[ERROR] %s, %s: expected %0h, actual %0h", test_name, what, expected, actual);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic report_failure(input string why);
    $display("%s during %s", why, test_name);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic set_word(input int idx, input logic [31:0] word,
                          input instr_class_e cls, input logic [31:0] imm);
    prog_word[idx] = word;
    prog_cls[idx]  = cls;
    prog_imm[idx]  = imm;
  endtask

  task automatic build_program();
    // addi x1, x0, idx keeps every filler word distinct
    for (int i = 0; i < prog_words_lp; i++)
      set_word(i, (i << 20) | 32'h0000_0093, e_class_other, '0);
    set_word(4, encode_jal(32'h30), e_class_jal, 32'h30);
    set_word(18, encode_beq(32'h38), e_class_branch, 32'h38);
    // jalr x0, 0(x1)
    set_word(21, 32'h0000_8067, e_class_jalr, '0);
    set_word(25, encode_jal(-100), e_class_jal, -100);
    set_word(34, encode_jal(-60), e_class_jal, -60);
    set_word(42, encode_jal(-80), e_class_jal, -80);
  endtask

  task automatic load_program();
    for (int i = 0; i < prog_words_lp; i++)
      begin
        @(posedge clk_i);
        imem_we_i    <= 1'b1;
        imem_addr_i  <= imem_addr_width_lp'(i);
        imem_wdata_i <= prog_word[i];
      end
    @(posedge clk_i);
    imem_we_i <= 1'b0;
  endtask

  task automatic send_redirect(input logic [31:0] pc);
    @(posedge clk_i);
    redirect_v_i  <= 1'b1;
    redirect_pc_i <= pc;
    @(posedge clk_i);
    redirect_v_i  <= 1'b0;
  endtask

  task automatic send_update(input logic [31:0] pc, input logic is_jalr,
                             input logic taken, input logic [31:0] target);
    @(posedge clk_i);
    update_v_i       <= 1'b1;
    update_pc_i      <= pc;
    update_is_jalr_i <= is_jalr;
    update_taken_i   <= taken;
    update_target_i  <= target;
    if (is_jalr)
      begin
        btb_v_m[pc[4:2]]   = 1'b1;
        btb_tag_m[pc[4:2]] = pc[12:5];
        btb_tgt_m[pc[4:2]] = target;
      end
    else if (taken && cnt_m[pc[7:2]] != 2'd3)
      cnt_m[pc[7:2]] = cnt_m[pc[7:2]] + 2'd1;
    else if (!taken && cnt_m[pc[7:2]] != 2'd0)
      cnt_m[pc[7:2]] = cnt_m[pc[7:2]] - 2'd1;
    @(posedge clk_i);
    update_v_i <= 1'b0;
  endtask

  task automatic wait_accepts(input int n);
    int target;
    target = accept_count + n;
    while (accept_count < target)
      @(posedge clk_i);
  endtask

  task automatic wait_halted();
    while (!halted_m)
      @(posedge clk_i);
    // no message may show up while halted
    repeat (6) @(posedge clk_i);
  endtask

  assign accept  = fetch_v_o && fetch_ready_i;
  assign out_vec = {fetch_msg_o, fetch_pred_taken_o, fetch_pc_o, fetch_instr_o};

  // prediction the model expects for the next message
  always_comb
    begin
      exp_taken  = 1'b0;
      exp_target = exp_pc + 32'd4;
      case (prog_cls[exp_pc[9:2]])
        e_class_jal:
          begin
            exp_taken  = 1'b1;
            exp_target = exp_pc + prog_imm[exp_pc[9:2]];
          end
        e_class_branch:
          begin
            exp_taken  = cnt_m[exp_pc[7:2]] >= 2'd2;
            exp_target = exp_pc + prog_imm[exp_pc[9:2]];
          end
        e_class_jalr:
          begin
            exp_taken  = btb_v_m[exp_pc[4:2]] && btb_tag_m[exp_pc[4:2]] == exp_pc[12:5];
            exp_target = btb_tgt_m[exp_pc[4:2]];
          end
        default: ;
      endcase
    end

  always @(posedge clk_i)
    begin
      if (reset_i)
        begin
          exp_pc      <= first_pc_lp;
          exp_exc     <= 1'b0;
          halted_m    <= 1'b0;
          was_stalled <= 1'b0;
        end
      else
        begin
          if (accept)
            begin
              accept_count <= accept_count + 1;
              if (exp_exc)
                begin
                  exp_exc  <= 1'b0;
                  halted_m <= 1'b1;
                end
              else
                exp_pc <= exp_taken ? exp_target : exp_pc + 32'd4;
            end
          // a redirect overrides whatever the accepted message implied
          if (redirect_v_i)
            begin
              exp_pc   <= redirect_pc_i;
              exp_exc  <= redirect_pc_i[1:0] != 2'b00;
              halted_m <= 1'b0;
            end
          was_stalled <= fetch_v_o && !fetch_ready_i && !redirect_v_i;
          prev_out    <= out_vec;
        end
    end

  always @(posedge clk_i)
    begin
      rnd_state     <= xorshift32(rnd_state);
      fetch_ready_i <= rnd_state[1:0] != 2'b00;
    end

  always @(posedge clk_i)
    begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= max_cycles_lp)
        begin
          $display("timeout after %0d cycles, the run did not finish", cycle_count);
          $display("RESULT: FAIL");
          $fatal(1);
        end
    end

  pc_check: assert property (@(posedge clk_i) disable iff (reset_i)
    accept |-> fetch_pc_o == exp_pc)
    else report_mismatch("pc", $sampled(exp_pc), $sampled(fetch_pc_o));

  kind_check: assert property (@(posedge clk_i) disable iff (reset_i)
    accept |-> fetch_msg_o == (exp_exc ? e_fe_exception : e_fe_fetch))
    else report_mismatch("message kind", $sampled(exp_exc), $sampled(fetch_msg_o));

  instr_check: assert property (@(posedge clk_i) disable iff (reset_i)
    accept |-> fetch_instr_o == (exp_exc ? '0 : prog_word[exp_pc[9:2]]))
    else report_mismatch("instruction",
                         $sampled(exp_exc ? '0 : prog_word[exp_pc[9:2]]),
                         $sampled(fetch_instr_o));

  pred_check: assert property (@(posedge clk_i) disable iff (reset_i)
    (accept && !exp_exc) |-> fetch_pred_taken_o == exp_taken)
    else report_mismatch("predicted taken", $sampled(exp_taken),
                         $sampled(fetch_pred_taken_o));

  halt_check: assert property (@(posedge clk_i) disable iff (reset_i)
    halted_m |-> !fetch_v_o)
    else report_failure("a message appeared while fetch was halted");

  hold_check: assert property (@(posedge clk_i) disable iff (reset_i)
    was_stalled |-> (fetch_v_o && out_vec == prev_out))
    else report_mismatch("held message", $sampled(prev_out), $sampled(out_vec));

  bubble_check: assert property (@(posedge clk_i)
    $fell(reset_i) |-> !fetch_v_o)
    else report_failure("valid was high in the first cycle after reset");

  initial
    begin
      reset_i          = 1'b1;
      imem_we_i        = 1'b0;
      imem_addr_i      = '0;
      imem_wdata_i     = '0;
      redirect_v_i     = 1'b0;
      redirect_pc_i    = '0;
      update_v_i       = 1'b0;
      update_pc_i      = '0;
      update_is_jalr_i = 1'b0;
      update_taken_i   = 1'b0;
      update_target_i  = '0;
      fetch_ready_i    = 1'b0;
      for (int i = 0; i < bht_entries_lp; i++)
        cnt_m[i] = 2'd1;
      for (int i = 0; i < btb_entries_lp; i++)
        btb_v_m[i] = 1'b0;

      build_program();
      // reset covers the load and three more cycles
      load_program();
      repeat (3) @(posedge clk_i);
      reset_i <= 1'b0;

      test_name = "sequential fetch and jal";
      wait_accepts(40);

      test_name = "aligned redirect";
      send_redirect(32'h44);
      wait_accepts(10);

      test_name = "misaligned redirect";
      send_redirect(32'h42);
      wait_halted();

      // branch at 0x48 jumps to 0x80 and jalr at 0x54 to 0xa0
      test_name = "branch and jalr training";
      send_update(32'h48, 1'b0, 1'b1, '0);
      send_update(32'h54, 1'b1, 1'b1, 32'ha0);
      send_redirect(32'h00);
      wait_accepts(40);

      // third not-taken update saturates at zero
      test_name = "branch retrain";
      send_redirect(32'h81);
      wait_halted();
      repeat (3) send_update(32'h48, 1'b0, 1'b0, '0);
      send_redirect(32'h40);
      wait_accepts(20);

      $display("RESULT: PASS");
      $finish;
    end

endmodule

`default_nettype wire

// File: project.f
verilog/fe_pkg.sv
verilog/fe_instr_scan.sv
verilog/fe_bht.sv
verilog/fe_btb.sv
verilog/fe_imem.sv
verilog/fe_pc_gen.sv
verilog/fe_top.sv
sim/tb_fe.sv

// File: Bender.yml
package:
  name: fe_frontend

sources:
  - files:
      - verilog/fe_pkg.sv
      - verilog/fe_instr_scan.sv
      - verilog/fe_bht.sv
      - verilog/fe_btb.sv
      - verilog/fe_imem.sv
      - verilog/fe_pc_gen.sv
      - verilog/fe_top.sv
  - target: simulation
    files:
      - sim/tb_fe.sv
